/* verilog/rom_pkg.sv */
package rom_pkg;

    // address and data geometry of the shared ROM
    localparam int ADDR_W = 20;             // client byte address
    localparam int WORD_W = 32;             // one ROM word on the AXI side

    // one full ROM word as it comes back from the read port
    typedef logic [WORD_W-1:0] word_t;

    // word address, byte address with the two low bits dropped
    typedef logic [ADDR_W-3:0] waddr_t;

    // client payloads, picked per slot through the cache type parameter
    typedef logic [7:0]  byte_t;            // client 0, byte reads
    typedef logic [15:0] half_t;            // client 1, half reads

    // AXI read response codes
    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

/* verilog/rom_slot_cache.sv */
`timescale 1ns/1ns

module rom_slot_cache #(
    parameter type data_t    = rom_pkg::byte_t,
    parameter bit  INVERT_A0 = 1'b0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [rom_pkg::ADDR_W-1:0] addr,      // client byte address
    input  logic                     addr_ok,     // addr is valid, held until data_ok
    output logic                     req,         // miss, word wanted from memory
    output rom_pkg::waddr_t          req_addr,
    input  logic                     fill_ok,     // fill strobe from the arbiter
    input  rom_pkg::word_t           fill_data,
    output logic                     data_ok,     // one cycle strobe to the client
    output data_t                    dout
);
    import rom_pkg::*;

    // lane geometry comes from the payload width
    localparam int DATA_W = $bits(data_t);
    localparam int LANES  = WORD_W / DATA_W;
    localparam int SEL_W  = $clog2(LANES);      // 2 for bytes, 1 for halves
    // flips only the lowest lane select bit
    localparam logic [SEL_W-1:0] A0_MASK = SEL_W'(INVERT_A0);

    waddr_t waddr;                  // word the client is pointing at

    // two cached words with their tags
    waddr_t tag0;
    waddr_t tag1;
    word_t  data0;
    word_t  data1;
    logic   valid0;
    logic   valid1;
    logic   repl;                   // entry to overwrite on the next fill

    logic             hit0;
    logic             hit1;
    logic             hit;
    logic [SEL_W-1:0] lane_sel;
    word_t            word_mux;

    assign waddr    = addr[ADDR_W-1:2];
    assign req_addr = waddr;

    assign hit0 = valid0 && (tag0 == waddr);
    assign hit1 = valid1 && (tag1 == waddr);
    assign hit  = hit0 || hit1;

    // no request for a word already cached, so a hit never touches the bus
    assign req = addr_ok && !hit;

    // lane from the low byte address bits
    assign lane_sel = addr[1 -: SEL_W] ^ A0_MASK;

    // a fresh fill bypasses the entries to save a cycle
    always_comb begin
        if (fill_ok) begin
            word_mux = fill_data;
        end else if (hit0) begin
            word_mux = data0;
        end else begin
            word_mux = data1;
        end
    end

    // control state, valid bits and replacement pointer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid0  <= 1'b0;
            valid1  <= 1'b0;
            repl    <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            // one strobe per request, a held address counts again only after it
            data_ok <= addr_ok && !data_ok && (hit || fill_ok);
            if (fill_ok) begin
                if (!valid0) begin
                    valid0 <= 1'b1;         // first fill lands in both entries
                    valid1 <= 1'b1;
                end else begin
                    repl <= ~repl;          // oldest goes next time
                end
            end
        end
    end

    // entry contents, written only by fills
    always_ff @(posedge clk) begin
        if (fill_ok) begin
            if (!valid0) begin
                tag0  <= waddr;
                data0 <= fill_data;
                tag1  <= waddr;
                data1 <= fill_data;
            end else if (repl) begin
                tag1  <= waddr;
                data1 <= fill_data;
            end else begin
                tag0  <= waddr;
                data0 <= fill_data;
            end
        end
    end

    // output lane, kept until the next delivery
    always_ff @(posedge clk) begin
        if (addr_ok && !data_ok && (hit || fill_ok)) begin
            dout <= data_t'(word_mux[lane_sel*DATA_W +: DATA_W]);
        end
    end

endmodule

/* verilog/rom_arbiter.sv */
`timescale 1ns/1ns

module rom_arbiter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req0,           // slot 0 miss, has priority
    input  logic            req1,
    input  rom_pkg::waddr_t req_addr0,
    input  rom_pkg::waddr_t req_addr1,
    output logic            fill_ok0,
    output logic            fill_ok1,
    output rom_pkg::word_t  fill_data,      // shared by both slots
    output logic            rd_start,       // one cycle kick to the read port
    output rom_pkg::waddr_t rd_addr,
    input  logic            rd_busy,
    input  logic            rd_done,
    input  rom_pkg::word_t  rd_data
);
    import rom_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_FILL
    } state_t;

    state_t state;
    logic   owner;          // slot whose word is on the bus
    logic   grant;          // idle and some slot asking
    logic   grant_sel;      // 0 when slot 0 wins
    waddr_t grant_addr;

    // fixed priority pick
    assign grant_sel  = !req0;
    assign grant_addr = req0 ? req_addr0 : req_addr1;

    // requests only looked at in idle, a dropped one is never started
    assign grant = (state == ST_IDLE) && (req0 || req1) && !rd_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            rd_start <= 1'b0;
            fill_ok0 <= 1'b0;
            fill_ok1 <= 1'b0;
        end else begin
            rd_start <= 1'b0;           // strobes default low
            fill_ok0 <= 1'b0;
            fill_ok1 <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (grant) begin
                        rd_start <= 1'b1;
                        state    <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (rd_done) begin
                        // route the word back to whoever asked
                        fill_ok0 <= !owner;
                        fill_ok1 <= owner;
                        state    <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    state <= ST_IDLE;   // req drops now that the entry hits
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // read address, owner and returned word
    always_ff @(posedge clk) begin
        if (grant) begin
            rd_addr <= grant_addr;
            owner   <= grant_sel;
        end
        if (state == ST_READ && rd_done) begin
            fill_data <= rd_data;
        end
    end

endmodule

/* verilog/axil_rd_port.sv */
`timescale 1ns/1ns

module axil_rd_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rd_start,
    input  rom_pkg::waddr_t            rd_addr,
    output logic                       rd_busy,
    output logic                       rd_done,
    output rom_pkg::word_t             rd_data,
    // AXI4-Lite read address channel
    output logic                       arvalid,
    input  logic                       arready,
    output logic [rom_pkg::ADDR_W-1:0] araddr,
    output logic [2:0]                 arprot,
    // AXI4-Lite read data channel
    input  logic                       rvalid,
    output logic                       rready,
    input  rom_pkg::word_t             rdata,
    input  logic [1:0]                 rresp,
    output logic                       rom_err     // sticky until reset
);
    import rom_pkg::*;

    logic launch;           // accepted start
    logic ar_hs;            // address handshake this cycle
    logic r_hs;             // data handshake this cycle

    assign launch = rd_start && !rd_busy;
    assign ar_hs  = arvalid && arready;
    assign r_hs   = rready && rvalid;

    assign arprot = 3'b000;     // data, unprivileged

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
            rready  <= 1'b0;
            rd_busy <= 1'b0;
            rd_done <= 1'b0;
            rom_err <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            if (launch) begin
                arvalid <= 1'b1;    // address goes out next cycle
                rd_busy <= 1'b1;
            end
            if (ar_hs) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;    // now wait for the data beat
            end
            if (r_hs) begin
                rready  <= 1'b0;
                rd_done <= 1'b1;
                rd_busy <= 1'b0;
                if (rresp != RESP_OKAY) begin
                    rom_err <= 1'b1;
                end
            end
        end
    end

    // address held stable while arvalid is up
    always_ff @(posedge clk) begin
        if (launch) begin
            araddr <= {rd_addr, 2'b00};
        end
        if (r_hs) begin
            rd_data <= rdata;
        end
    end

endmodule

/* verilog/rom_fetch_top.sv */
`timescale 1ns/1ns

module rom_fetch_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // client 0, byte reads
    input  logic [rom_pkg::ADDR_W-1:0] c0_addr,
    input  logic                       c0_addr_ok,
    output logic                       c0_data_ok,
    output rom_pkg::byte_t             c0_dout,
    // client 1, half reads with swapped halves
    input  logic [rom_pkg::ADDR_W-1:0] c1_addr,
    input  logic                       c1_addr_ok,
    output logic                       c1_data_ok,
    output rom_pkg::half_t             c1_dout,
    // AXI4-Lite read channels
    output logic                       arvalid,
    input  logic                       arready,
    output logic [rom_pkg::ADDR_W-1:0] araddr,
    output logic [2:0]                 arprot,
    input  logic                       rvalid,
    output logic                       rready,
    input  rom_pkg::word_t             rdata,
    input  logic [1:0]                 rresp,
    output logic                       rom_err
);
    import rom_pkg::*;

    // cache to arbiter
    logic   req0;
    logic   req1;
    waddr_t req_addr0;
    waddr_t req_addr1;
    logic   fill_ok0;
    logic   fill_ok1;
    word_t  fill_data;

    // arbiter to read port
    logic   rd_start;
    waddr_t rd_addr;
    logic   rd_busy;
    logic   rd_done;
    word_t  rd_data;

    rom_slot_cache #(
        .data_t    (byte_t),
        .INVERT_A0 (1'b0)
    ) i_slot0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (c0_addr),
        .addr_ok   (c0_addr_ok),
        .req       (req0),
        .req_addr  (req_addr0),
        .fill_ok   (fill_ok0),
        .fill_data (fill_data),
        .data_ok   (c0_data_ok),
        .dout      (c0_dout)
    );

    rom_slot_cache #(
        .data_t    (half_t),
        .INVERT_A0 (1'b1)        // halves swapped within the word
    ) i_slot1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (c1_addr),
        .addr_ok   (c1_addr_ok),
        .req       (req1),
        .req_addr  (req_addr1),
        .fill_ok   (fill_ok1),
        .fill_data (fill_data),
        .data_ok   (c1_data_ok),
        .dout      (c1_dout)
    );

    rom_arbiter i_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .req0      (req0),
        .req1      (req1),
        .req_addr0 (req_addr0),
        .req_addr1 (req_addr1),
        .fill_ok0  (fill_ok0),
        .fill_ok1  (fill_ok1),
        .fill_data (fill_data),
        .rd_start  (rd_start),
        .rd_addr   (rd_addr),
        .rd_busy   (rd_busy),
        .rd_done   (rd_done),
        .rd_data   (rd_data)
    );

    axil_rd_port i_axil_rd_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_start (rd_start),
        .rd_addr  (rd_addr),
        .rd_busy  (rd_busy),
        .rd_done  (rd_done),
        .rd_data  (rd_data),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .arprot   (arprot),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rom_err  (rom_err)
    );

endmodule

/* verif/axil_rom_model.sv */
`timescale 1ns/1ns

module axil_rom_model #(
    parameter logic [rom_pkg::ADDR_W-1:0] ERR_LO = '1,   // first byte of the error window
    parameter logic [rom_pkg::ADDR_W-1:0] ERR_HI = '1
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ar_stall,    // hold arready low this cycle
    input  logic                       r_stall,     // hold back rvalid this cycle
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [rom_pkg::ADDR_W-1:0] araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output rom_pkg::word_t             rdata,
    output logic [1:0]                 rresp
);
    import rom_pkg::*;

    logic                pend;          // address taken but data not yet accepted
    logic [ADDR_W-1:0]   addr_q;

    // upper half holds the inverse of the word address and lower half the address itself
    function automatic word_t rom_word(input waddr_t w);
        return {~w[15:0], w[15:0]};
    endfunction

    assign arready = !ar_stall && !pend;    // one read at a time

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend   <= 1'b0;
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= RESP_OKAY;
        end else begin
            if (arvalid && arready) begin
                pend   <= 1'b1;
                addr_q <= araddr;
            end
            if (pend && !rvalid && !r_stall) begin
                rvalid <= 1'b1;
                rdata  <= rom_word(addr_q[ADDR_W-1:2]);
                if (addr_q >= ERR_LO && addr_q <= ERR_HI) begin
                    rresp <= 2'b10;         // SLVERR inside the window
                end else begin
                    rresp <= RESP_OKAY;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                pend   <= 1'b0;
            end
        end
    end

endmodule

/* verif/tb_rom_fetch.sv */
`timescale 1ns/1ns

module tb_rom_fetch;
    import rom_pkg::*;

    localparam int N_READS = 43;                    // 32 solo, 8 paired, 3 error phase
    localparam int LIMIT   = 40 * N_READS + 200;
    localparam logic [ADDR_W-1:0] ERR_LO = 20'hff000;
    localparam logic [ADDR_W-1:0] ERR_HI = 20'hfffff;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [ADDR_W-1:0] c0_addr;
    logic              c0_addr_ok;
    logic              c0_data_ok;
    byte_t             c0_dout;
    logic [ADDR_W-1:0] c1_addr;
    logic              c1_addr_ok;
    logic              c1_data_ok;
    half_t             c1_dout;
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic [2:0]        arprot;
    logic              rvalid;
    logic              rready;
    word_t             rdata;
    logic [1:0]        rresp;
    logic              rom_err;
    logic              ar_stall = 1'b0;
    logic              r_stall  = 1'b0;

    logic [31:0]       stim_rng  = 32'h84a5_b660;
    logic [31:0]       stall_rng = 32'h84a5_b660;   // separate stream for stalls
    int                cycles    = 0;
    int                ar_count  = 0;
    logic [ADDR_W-1:0] ar_log[$];       // every accepted read address
    logic              err_sticky = 1'b0;

    // scoreboard copy of each client cache
    waddr_t            mtag   [2][2];
    logic              mvalid [2];
    logic              mrepl  [2];

    always #2 clk = ~clk;

    rom_fetch_top i_rom_fetch_top (
        .clk(clk), .rst_n(rst_n),
        .c0_addr(c0_addr), .c0_addr_ok(c0_addr_ok), .c0_data_ok(c0_data_ok), .c0_dout(c0_dout),
        .c1_addr(c1_addr), .c1_addr_ok(c1_addr_ok), .c1_data_ok(c1_data_ok), .c1_dout(c1_dout),
        .arvalid(arvalid), .arready(arready), .araddr(araddr), .arprot(arprot),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp), .rom_err(rom_err)
    );

    axil_rom_model #(.ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) i_rom_model (
        .clk(clk), .rst_n(rst_n), .ar_stall(ar_stall), .r_stall(r_stall),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected payloads straight from the content rule
    function automatic byte_t expect_byte(input logic [ADDR_W-1:0] a);
        logic [31:0] w;
        w = {~a[17:2], a[17:2]};
        return byte_t'(w >> (8 * a[1:0]));
    endfunction

    function automatic half_t expect_half(input logic [ADDR_W-1:0] a);
        logic [31:0] w;
        w = {~a[17:2], a[17:2]};
        return half_t'(w >> (16 * {4'd0, ~a[1]}));   // halves swapped
    endfunction

    function automatic logic model_hit(input int c, input waddr_t w);
        return mvalid[c] && (mtag[c][0] == w || mtag[c][1] == w);
    endfunction

    function automatic void model_fill(input int c, input waddr_t w);
        if (!mvalid[c]) begin
            mtag[c][0] = w;         // first fill takes both entries
            mtag[c][1] = w;
            mvalid[c]  = 1'b1;
        end else begin
            mtag[c][mrepl[c]] = w;
            mrepl[c] = ~mrepl[c];
        end
    endfunction

    task automatic stop_on_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic stop_on_error(input string msg);
        $display("Error: %s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    // solo marks a read with no other client active, so AXI traffic is attributable
    task automatic read_c0(input logic [ADDR_W-1:0] a, input bit solo);
        int    waited;
        int    ar_before;
        logic  hit;
        byte_t exp;
        hit       = model_hit(0, a[ADDR_W-1:2]);
        exp       = expect_byte(a);
        ar_before = ar_count;
        @(posedge clk);
        c0_addr    <= a;
        c0_addr_ok <= 1'b1;
        @(negedge clk);
        waited = 0;
        while (!c0_data_ok) begin
            @(negedge clk);
            waited++;
        end
        assert (c0_dout == exp) else stop_on_value("c0_dout", 32'(c0_dout), 32'(exp));
        if (hit) begin
            assert (waited == 1) else stop_on_error("client 0 hit did not answer in one cycle");
        end
        if (solo) begin
            assert (ar_count == ar_before + (hit ? 0 : 1))
                else stop_on_value("ar_count", 32'(ar_count), 32'(ar_before + (hit ? 0 : 1)));
        end
        if (!hit) model_fill(0, a[ADDR_W-1:2]);
        @(posedge clk);
        c0_addr_ok <= 1'b0;
    endtask

    task automatic read_c1(input logic [ADDR_W-1:0] a, input bit solo);
        int    waited;
        int    ar_before;
        logic  hit;
        half_t exp;
        hit       = model_hit(1, a[ADDR_W-1:2]);
        exp       = expect_half(a);
        ar_before = ar_count;
        @(posedge clk);
        c1_addr    <= a;
        c1_addr_ok <= 1'b1;
        @(negedge clk);
        waited = 0;
        while (!c1_data_ok) begin
            @(negedge clk);
            waited++;
        end
        assert (c1_dout == exp) else stop_on_value("c1_dout", 32'(c1_dout), 32'(exp));
        if (hit) begin
            assert (waited == 1) else stop_on_error("client 1 hit did not answer in one cycle");
        end
        if (solo) begin
            assert (ar_count == ar_before + (hit ? 0 : 1))
                else stop_on_value("ar_count", 32'(ar_count), 32'(ar_before + (hit ? 0 : 1)));
        end
        if (!hit) model_fill(1, a[ADDR_W-1:2]);
        @(posedge clk);
        c1_addr_ok <= 1'b0;
    endtask

    // stall pattern for the memory model
    always @(posedge clk) begin
        stall_rng = xorshift32(stall_rng);
        ar_stall <= stall_rng[2:0] < 3'd3;
        r_stall  <= stall_rng[5:3] < 3'd3;
    end

    // bus monitor sampling at the falling edge where inputs are stable
    always @(negedge clk) begin
        if (rst_n) begin
            assert (rom_err == err_sticky)
                else stop_on_value("rom_err", 32'(rom_err), 32'(err_sticky));
            if (arvalid) begin
                assert (arprot == 3'b000) else stop_on_value("arprot", 32'(arprot), 32'h0);
            end
            if (arvalid && arready) begin   // handshake at the coming edge
                ar_count++;
                ar_log.push_back(araddr);
            end
            if (rvalid && rready && rresp != RESP_OKAY) err_sticky = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) stop_on_error("timeout, reads did not complete in time");
    end

    initial begin
        int                c;
        int                i;
        int                n_before;
        waddr_t            wbase;
        waddr_t            words[3];
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] a0;
        logic [ADDR_W-1:0] a1;
        rst_n      = 1'b0;
        c0_addr    = '0;
        c0_addr_ok = 1'b0;
        c1_addr    = '0;
        c1_addr_ok = 1'b0;
        for (c = 0; c < 2; c++) begin
            mvalid[c] = 1'b0;
            mrepl[c]  = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!c0_data_ok && !c1_data_ok && !arvalid && !rready && !rom_err)
            else stop_on_error("a control output is high right after reset");

        // each client alone cycles three words through two entries
        for (c = 0; c < 2; c++) begin
            stim_rng = xorshift32(stim_rng);
            wbase    = waddr_t'(stim_rng[17:0] & 18'h0fff0);
            words[0] = wbase;
            words[1] = wbase + 5;
            words[2] = wbase + 9;
            for (i = 0; i < 16; i++) begin
                stim_rng = xorshift32(stim_rng);
                a = {words[int'(stim_rng[9:8]) % 3], stim_rng[1:0]};
                idle(int'(stim_rng[5:4]));
                if (c == 0) read_c0(a, 1'b1);
                else read_c1(a, 1'b1);
            end
        end

        // both clients miss together and slot 0 goes first
        for (i = 0; i < 4; i++) begin
            stim_rng = xorshift32(stim_rng);
            a0 = 20'h40000 + 20'(i) * 20'h100 + 20'(stim_rng[1:0]);
            a1 = 20'h60000 + 20'(i) * 20'h100 + 20'(stim_rng[3:2]);
            idle(int'(stim_rng[5:4]));
            n_before = ar_log.size();
            fork
                read_c0(a0, 1'b0);
                read_c1(a1, 1'b0);
            join
            assert (ar_log[n_before] == {a0[ADDR_W-1:2], 2'b00})
                else stop_on_value("araddr", 32'(ar_log[n_before]), 32'({a0[ADDR_W-1:2], 2'b00}));
        end

        // error window read followed by normal reads with rom_err held
        read_c0(ERR_LO + 20'h6, 1'b1);
        stim_rng = xorshift32(stim_rng);
        read_c1({2'b00, stim_rng[17:0]}, 1'b1);
        read_c1({2'b00, stim_rng[17:0]} + 20'h40, 1'b1);
        idle(4);
        if (rom_err) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_on_value("rom_err", 32'(rom_err), 32'h1);
        end
    end

endmodule

/* files.f */
verilog/rom_pkg.sv
verilog/rom_slot_cache.sv
verilog/rom_arbiter.sv
verilog/axil_rd_port.sv
verilog/rom_fetch_top.sv
verif/axil_rom_model.sv
verif/tb_rom_fetch.sv

/* Makefile */
# Verilator build and run for the ROM fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_rom_fetch
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
